/* ntm_hidden_gate_pkg.sv */
/*
 * NTM hidden gate shared definitions
 * Default fixed-point widths for the hidden-state datapath
 * and the state encoding of the element controller
 */

package ntm_hidden_gate_pkg;

  ////////////////////
  // Fixed-point format
  ////////////////////

  // Signed element width
  parameter int DEFAULT_DATA_SIZE = 16;

  // Fraction bits, so 1.0 is 256
  parameter int DEFAULT_FRAC_SIZE = 8;

  // Vector length and element counter width
  parameter int DEFAULT_LENGTH_SIZE = 8;

  ////////////////////
  // Controller states
  ////////////////////

  // Element request and count sequence
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    REQUEST    = 3'd1,
    WAIT_INPUT = 3'd2,
    COMPUTE    = 3'd3,
    DONE       = 3'd4
  } gate_state_t;

endpackage

/* ntm_vector_tanh.sv */
/*
 * NTM element tanh
 * Two-stage piecewise-linear tanh of one signed fixed-point element
 * Segments are identity, quarter plus half slope, and saturation at 1.0
 */

module ntm_vector_tanh #(
  parameter int DATA_SIZE = ntm_hidden_gate_pkg::DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE = ntm_hidden_gate_pkg::DEFAULT_FRAC_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 data_in_enable,
  input  logic [DATA_SIZE-1:0] data_in,
  output logic                 data_out_enable,
  output logic [DATA_SIZE-1:0] data_out
);

  // Fixed-point breakpoints and levels
  localparam logic [DATA_SIZE-1:0] FP_QUARTER  = DATA_SIZE'(1) << (FRAC_SIZE - 2);
  localparam logic [DATA_SIZE-1:0] FP_HALF     = DATA_SIZE'(1) << (FRAC_SIZE - 1);
  localparam logic [DATA_SIZE-1:0] FP_ONE      = DATA_SIZE'(1) << FRAC_SIZE;
  localparam logic [DATA_SIZE-1:0] FP_ONE_HALF = FP_ONE + FP_HALF;

  // Segment codes
  localparam logic [1:0] SEG_LINEAR = 2'd0;
  localparam logic [1:0] SEG_SLOPE  = 2'd1;
  localparam logic [1:0] SEG_SAT    = 2'd2;

  logic [DATA_SIZE-1:0] abs_x;
  logic [1:0]           seg_sel;

  // Stage 1 registers
  logic                 valid_s1;
  logic                 neg_s1;
  logic [1:0]           seg_s1;
  logic [DATA_SIZE-1:0] mag_s1;

  // Stage 2 segment value before sign
  logic [DATA_SIZE-1:0] y_mag;

  ////////////////////
  // Stage 1
  ////////////////////

  assign abs_x = data_in[DATA_SIZE-1] ? -data_in : data_in;

  // Breakpoints at 0.5 and 1.5
  // Most negative code keeps its top bit as magnitude and saturates
  assign seg_sel = (abs_x < FP_HALF)     ? SEG_LINEAR :
                   (abs_x < FP_ONE_HALF) ? SEG_SLOPE : SEG_SAT;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= data_in_enable;
    end
  end

  // Operand fields only move with a new element
  always_ff @(posedge CLK) begin
    if (data_in_enable) begin
      neg_s1 <= data_in[DATA_SIZE-1];
      seg_s1 <= seg_sel;
      mag_s1 <= abs_x;
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////

  always_comb begin
    case (seg_s1)
      SEG_LINEAR: y_mag = mag_s1;
      // Floor halving of the magnitude
      SEG_SLOPE:  y_mag = FP_QUARTER + (mag_s1 >> 1);
      default:    y_mag = FP_ONE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out_enable <= 1'b0;
    end else begin
      data_out_enable <= valid_s1;
    end
  end

  // Odd function so the sign is put back last
  always_ff @(posedge CLK) begin
    if (valid_s1) begin
      data_out <= neg_s1 ? -y_mag : y_mag;
    end
  end

  // One element per strobe with a gap between strobes
  assert property (@(posedge CLK) disable iff (RST)
    data_in_enable |=> !data_in_enable);

endmodule

/* ntm_vector_multiplier.sv */
/*
 * NTM element multiplier
 * One-stage signed fixed-point product of two elements
 * Rescaled by the fraction width and saturated to the element range
 */

module ntm_vector_multiplier #(
  parameter int DATA_SIZE = ntm_hidden_gate_pkg::DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE = ntm_hidden_gate_pkg::DEFAULT_FRAC_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 data_in_enable,
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,
  output logic                 data_out_enable,
  output logic [DATA_SIZE-1:0] data_out
);

  // Element range limits
  localparam logic [DATA_SIZE-1:0] MAX_VALUE = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic [DATA_SIZE-1:0] MIN_VALUE = {1'b1, {(DATA_SIZE-1){1'b0}}};

  logic signed [2*DATA_SIZE-1:0] product;
  logic signed [2*DATA_SIZE-1:0] scaled;
  logic                          pos_ovf;
  logic                          neg_ovf;
  logic [DATA_SIZE-1:0]          result;

  ////////////////////
  // Product and rescale
  ////////////////////

  // Full width so no bits are lost before the shift
  assign product = $signed(data_a_in) * $signed(data_b_in);

  // Arithmetic shift rounds toward minus infinity
  assign scaled = product >>> FRAC_SIZE;

  ////////////////////
  // Saturation
  ////////////////////

  // Upper bits must all match the element sign bit
  assign pos_ovf = !scaled[2*DATA_SIZE-1] && (|scaled[2*DATA_SIZE-2:DATA_SIZE-1]);
  assign neg_ovf = scaled[2*DATA_SIZE-1] && !(&scaled[2*DATA_SIZE-2:DATA_SIZE-1]);

  always_comb begin
    if (pos_ovf) begin
      result = MAX_VALUE;
    end else if (neg_ovf) begin
      result = MIN_VALUE;
    end else begin
      result = scaled[DATA_SIZE-1:0];
    end
  end

  // Result register with its strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out_enable <= 1'b0;
      data_out        <= '0;
    end else begin
      data_out_enable <= data_in_enable;
      if (data_in_enable) begin
        data_out <= result;
      end
    end
  end

  // Operands from the controller and the tanh unit are settled
  assert property (@(posedge CLK) disable iff (RST)
    data_in_enable |-> !$isunknown({data_a_in, data_b_in}));

endmodule

/* ntm_hidden_gate_vector.sv */
/*
 * NTM hidden gate vector
 * h(l) = o(l) * tanh(s(l)) for l from 0 to L-1 in signed fixed point
 * Requests one element at a time, waits for both operands,
 * runs them through tanh and the multiplier, then pulses ready
 */

module ntm_hidden_gate_vector #(
  parameter int DATA_SIZE   = ntm_hidden_gate_pkg::DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE   = ntm_hidden_gate_pkg::DEFAULT_FRAC_SIZE,
  parameter int LENGTH_SIZE = ntm_hidden_gate_pkg::DEFAULT_LENGTH_SIZE
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  output logic                   ready,
  input  logic                   s_in_enable,
  input  logic                   o_in_enable,
  output logic                   s_out_enable,
  output logic                   o_out_enable,
  output logic                   h_out_enable,
  input  logic [LENGTH_SIZE-1:0] size_l_in,
  input  logic [DATA_SIZE-1:0]   s_in,
  input  logic [DATA_SIZE-1:0]   o_in,
  output logic [DATA_SIZE-1:0]   h_out
);

  import ntm_hidden_gate_pkg::*;

  gate_state_t state;

  // Vector length and element index
  logic [LENGTH_SIZE-1:0] length_l;
  logic [LENGTH_SIZE-1:0] elem_count;
  logic                   last_elem;

  // Operand arrival flags
  logic s_received;
  logic o_received;

  // Operand registers
  logic [DATA_SIZE-1:0] s_reg;
  logic [DATA_SIZE-1:0] o_reg;

  // Tanh unit handshake
  logic                 tanh_in_enable;
  logic                 tanh_out_enable;
  logic [DATA_SIZE-1:0] tanh_out;

  assign last_elem = (elem_count == length_l - LENGTH_SIZE'(1));

  ////////////////////
  // Controller FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE;
      ready          <= 1'b0;
      s_out_enable   <= 1'b0;
      o_out_enable   <= 1'b0;
      tanh_in_enable <= 1'b0;
      s_received     <= 1'b0;
      o_received     <= 1'b0;
      length_l       <= '0;
      elem_count     <= '0;
    end else begin
      // Strobes last one cycle
      ready          <= 1'b0;
      s_out_enable   <= 1'b0;
      o_out_enable   <= 1'b0;
      tanh_in_enable <= 1'b0;

      case (state)
        IDLE: begin
          if (start) begin
            length_l   <= size_l_in;
            elem_count <= '0;
            state      <= REQUEST;
          end
        end

        // First element request
        REQUEST: begin
          s_out_enable <= 1'b1;
          o_out_enable <= 1'b1;
          state        <= WAIT_INPUT;
        end

        // s and o may arrive in either order
        WAIT_INPUT: begin
          if (s_received && o_received) begin
            tanh_in_enable <= 1'b1;
            s_received     <= 1'b0;
            o_received     <= 1'b0;
            state          <= COMPUTE;
          end else begin
            if (s_in_enable) begin
              s_received <= 1'b1;
            end
            if (o_in_enable) begin
              o_received <= 1'b1;
            end
          end
        end

        // Wait for the multiplier strobe
        COMPUTE: begin
          if (h_out_enable) begin
            elem_count <= elem_count + LENGTH_SIZE'(1);
            if (last_elem) begin
              ready <= 1'b1;
              state <= DONE;
            end else begin
              s_out_enable <= 1'b1;
              o_out_enable <= 1'b1;
              state        <= WAIT_INPUT;
            end
          end
        end

        // ready high in this cycle
        DONE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Operand capture
  ////////////////////

  always_ff @(posedge CLK) begin
    if (state == WAIT_INPUT && s_in_enable) begin
      s_reg <= s_in;
    end
    if (state == WAIT_INPUT && o_in_enable) begin
      o_reg <= o_in;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  // tanh(s), two cycles
  ntm_vector_tanh #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) vector_tanh (
    .CLK            (CLK),
    .RST            (RST),
    .data_in_enable (tanh_in_enable),
    .data_in        (s_reg),
    .data_out_enable(tanh_out_enable),
    .data_out       (tanh_out)
  );

  // o * tanh(s), one cycle, straight to the outputs
  ntm_vector_multiplier #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) vector_multiplier (
    .CLK            (CLK),
    .RST            (RST),
    .data_in_enable (tanh_out_enable),
    .data_a_in      (o_reg),
    .data_b_in      (tanh_out),
    .data_out_enable(h_out_enable),
    .data_out       (h_out)
  );

  // Empty vectors are not supported
  assert property (@(posedge CLK) disable iff (RST)
    (state == IDLE && start) |-> (size_l_in != '0));

  // One answer per request on each operand
  assert property (@(posedge CLK) disable iff (RST)
    !(s_in_enable && s_received) && !(o_in_enable && o_received));

  // Source answers only an open request
  assert property (@(posedge CLK) disable iff (RST)
    (s_in_enable || o_in_enable) |-> (state == WAIT_INPUT));

endmodule

/* ntm_hidden_gate_vector_tb.sv */
/*
 * NTM hidden gate vector testbench
 * Source model answering element requests after random delays,
 * reference model of o * tanh(s), output and latency checker,
 * cycle-count timeout and a closing report
 */

module ntm_hidden_gate_vector_tb;

  import ntm_hidden_gate_pkg::*;

  localparam int DATA_SIZE   = DEFAULT_DATA_SIZE;
  localparam int FRAC_SIZE   = DEFAULT_FRAC_SIZE;
  localparam int LENGTH_SIZE = DEFAULT_LENGTH_SIZE;

  localparam int HALF_PERIOD    = 20;
  localparam int DRIVE_DELAY    = 5;
  localparam int RESULT_LATENCY = 4;
  localparam int RANDOM_RUNS    = 6;
  localparam int DIRECTED_LEN   = 16;
  localparam int SAT_LEN        = 2;
  localparam int MID_START_LEN  = 5;

  // Fixed-point levels of the tanh segments
  localparam int QUARTER_FP  = 1 << (FRAC_SIZE - 2);
  localparam int HALF_FP     = 1 << (FRAC_SIZE - 1);
  localparam int ONE_FP      = 1 << FRAC_SIZE;
  localparam int ONE_HALF_FP = ONE_FP + HALF_FP;

  // Element range
  localparam int MAX_VALUE = (1 << (DATA_SIZE - 1)) - 1;
  localparam int MIN_VALUE = -(1 << (DATA_SIZE - 1));

  // Random s spans about +-4.0, random o the full range
  localparam int S_SPAN = 4 * ONE_FP;
  localparam int O_SPAN = 1 << (DATA_SIZE - 1);

  logic                   CLK;
  logic                   RST;
  logic                   start;
  logic                   ready;
  logic                   s_in_enable;
  logic                   o_in_enable;
  logic                   s_out_enable;
  logic                   o_out_enable;
  logic                   h_out_enable;
  logic [LENGTH_SIZE-1:0] size_l_in;
  logic [DATA_SIZE-1:0]   s_in;
  logic [DATA_SIZE-1:0]   o_in;
  logic [DATA_SIZE-1:0]   h_out;

  integer seed = 32'h6014ebf4;
  int     max_delay = 0;

  // Pending operands and expected results, in element order
  int src_s [$];
  int src_o [$];
  int exp_q [$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int out_count = 0;
  int ready_count = 0;
  int cur_len = 0;
  int s_edge = 0;
  int o_edge = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int latency_checks = 0;
  int latency_errors = 0;
  int rand_len [RANDOM_RUNS];

  // Segment interiors, both boundaries, both signs, saturation
  int dir_s [DIRECTED_LEN] = '{0, 64, -64, 127, 128, -128, 255, -255,
                               383, 384, -384, 1000, -1000, 32767, -32768, 300};
  int dir_o [DIRECTED_LEN] = '{256, 256, 300, 256, 256, 256, -200, 256,
                               256, 256, 256, 500, 500, -700, 256, 32767};

  ntm_hidden_gate_vector #(
    .DATA_SIZE  (DATA_SIZE),
    .FRAC_SIZE  (FRAC_SIZE),
    .LENGTH_SIZE(LENGTH_SIZE)
  ) dut0 (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .ready       (ready),
    .s_in_enable (s_in_enable),
    .o_in_enable (o_in_enable),
    .s_out_enable(s_out_enable),
    .o_out_enable(o_out_enable),
    .h_out_enable(h_out_enable),
    .size_l_in   (size_l_in),
    .s_in        (s_in),
    .o_in        (o_in),
    .h_out       (h_out)
  );

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Piecewise-linear tanh, odd function
  function automatic int tanh_model(int x);
    int mag;
    int y;
    // Most negative code lands in saturation as a plain int
    mag = (x < 0) ? -x : x;
    if (mag < HALF_FP) begin
      y = mag;
    end else if (mag < ONE_HALF_FP) begin
      y = QUARTER_FP + (mag >> 1);
    end else begin
      y = ONE_FP;
    end
    return (x < 0) ? -y : y;
  endfunction

  // o * tanh(s), floor rescale then clamp
  function automatic int hidden_model(int s, int o);
    int p;
    p = (o * tanh_model(s)) >>> FRAC_SIZE;
    if (p > MAX_VALUE) begin
      p = MAX_VALUE;
    end else if (p < MIN_VALUE) begin
      p = MIN_VALUE;
    end
    return p;
  endfunction

  function automatic int pick_delay();
    return {$random(seed)} % (max_delay + 1);
  endfunction

  ////////////////////
  // Source model
  ////////////////////

  // s and o answer the same request independently
  always begin : s_source
    int d;
    @(posedge CLK);
    if (s_out_enable) begin
      d = pick_delay();
      repeat (d) @(posedge CLK);
      #DRIVE_DELAY;
      assert (src_s.size() > 0) else begin
        $display("Request for s at time %0t with no operand left", $time);
        error_count++;
      end
      s_in = DATA_SIZE'(src_s.pop_front());
      s_in_enable = 1'b1;
      @(posedge CLK);
      #DRIVE_DELAY;
      s_in_enable = 1'b0;
    end
  end

  always begin : o_source
    int d;
    @(posedge CLK);
    if (o_out_enable) begin
      d = pick_delay();
      repeat (d) @(posedge CLK);
      #DRIVE_DELAY;
      assert (src_o.size() > 0) else begin
        $display("Request for o at time %0t with no operand left", $time);
        error_count++;
      end
      o_in = DATA_SIZE'(src_o.pop_front());
      o_in_enable = 1'b1;
      @(posedge CLK);
      #DRIVE_DELAY;
      o_in_enable = 1'b0;
    end
  end

  ////////////////////
  // Checker
  ////////////////////

  task automatic check_output();
    int got;
    int expected;
    int late;
    got = int'($signed(h_out));
    out_count++;
    assert (exp_q.size() > 0) else begin
      $display("Unexpected h_out_enable at time %0t with no result pending", $time);
      error_count++;
    end
    if (exp_q.size() > 0) begin
      expected = exp_q.pop_front();
      check_count++;
      assert (got == expected) else begin
        $display("Mismatch at time %0t: h_out got %0d expected %0d", $time, got, expected);
        error_count++;
      end
    end
    // Seen one edge after it rose
    late = (s_edge > o_edge) ? s_edge : o_edge;
    latency_checks++;
    assert (cycle_count - 1 - late == RESULT_LATENCY) else begin
      $display("Mismatch at time %0t: h_out_enable latency got %0d expected %0d",
               $time, cycle_count - 1 - late, RESULT_LATENCY);
      error_count++;
      latency_errors++;
    end
  endtask

  // Edge count, timeout, and comparison against the queue
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
      $display("TEST FAIL");
      $finish;
    end else begin
      if (s_in_enable) begin
        s_edge = cycle_count;
      end
      if (o_in_enable) begin
        o_edge = cycle_count;
      end
      if (h_out_enable) begin
        check_output();
      end
      if (ready) begin
        ready_count++;
        assert (out_count == cur_len) else begin
          $display("ready pulsed at time %0t after %0d of %0d outputs",
                   $time, out_count, cur_len);
          error_count++;
        end
      end
    end
  end

  ////////////////////
  // Test tasks
  ////////////////////

  task automatic check_low(input string name, input logic [DATA_SIZE-1:0] value);
    check_count++;
    assert (value == '0) else begin
      $display("Mismatch at time %0t: %s got %0h expected 0", $time, name, value);
      error_count++;
    end
  endtask

  task automatic check_idle_outputs();
    check_low("ready", DATA_SIZE'(ready));
    check_low("s_out_enable", DATA_SIZE'(s_out_enable));
    check_low("o_out_enable", DATA_SIZE'(o_out_enable));
    check_low("h_out_enable", DATA_SIZE'(h_out_enable));
    check_low("h_out", h_out);
  endtask

  task automatic queue_element(input int s, input int o, input int expected);
    src_s.push_back(s);
    src_o.push_back(o);
    exp_q.push_back(expected);
  endtask

  task automatic queue_random(input int len);
    int s;
    int o;
    for (int i = 0; i < len; i++) begin
      s = $random(seed) % S_SPAN;
      o = $random(seed) % O_SPAN;
      queue_element(s, o, hidden_model(s, o));
    end
  endtask

  // Starts a vector of queued elements and waits for ready
  task automatic run_vector(input int len, input int delay_limit, input bit mid_start);
    bit injected;
    injected = 1'b0;
    out_count = 0;
    ready_count = 0;
    cur_len = len;
    max_delay = delay_limit;
    start = 1'b1;
    size_l_in = LENGTH_SIZE'(len);
    @(posedge CLK);
    #DRIVE_DELAY;
    start = 1'b0;
    while (ready_count == 0) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      // Second start while busy, with a different length
      if (mid_start && !injected && out_count >= 2) begin
        injected = 1'b1;
        start = 1'b1;
        size_l_in = LENGTH_SIZE'(2);
        @(posedge CLK);
        #DRIVE_DELAY;
        start = 1'b0;
        size_l_in = LENGTH_SIZE'(len);
      end
    end
    // Quiet cycles to catch a stray output or ready
    repeat (3) @(posedge CLK);
    #DRIVE_DELAY;
    check_count++;
    assert (out_count == len && ready_count == 1 && exp_q.size() == 0) else begin
      $display("Mismatch at time %0t: out_count got %0d expected %0d, ready pulses %0d",
               $time, out_count, len, ready_count);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: FAILED with %0d errors", test_count, name,
               error_count - errors_before);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int total;
    int errors_before;
    RST = 1'b1;
    start = 1'b0;
    s_in_enable = 1'b0;
    o_in_enable = 1'b0;
    size_l_in = '0;
    s_in = '0;
    o_in = '0;

    // Lengths first, so the cycle budget is known up front
    total = DIRECTED_LEN + SAT_LEN + MID_START_LEN;
    for (int i = 0; i < RANDOM_RUNS; i++) begin
      rand_len[i] = 1 + {$random(seed)} % 12;
      total += rand_len[i];
    end
    cycle_limit = total * 9 + 50;

    errors_before = error_count;
    repeat (2) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      check_idle_outputs();
    end
    RST = 1'b0;
    @(posedge CLK);
    #DRIVE_DELAY;
    check_idle_outputs();
    report_test("reset state", errors_before);

    errors_before = error_count;
    for (int i = 0; i < DIRECTED_LEN; i++) begin
      queue_element(dir_s[i], dir_o[i], hidden_model(dir_s[i], dir_o[i]));
    end
    run_vector(DIRECTED_LEN, 0, 1'b0);
    report_test("directed tanh segments", errors_before);

    // o at the most negative value against tanh of +-1.0
    errors_before = error_count;
    queue_element(-2000, MIN_VALUE, MAX_VALUE);
    queue_element(2000, MIN_VALUE, MIN_VALUE);
    run_vector(SAT_LEN, 0, 1'b0);
    report_test("product saturation", errors_before);

    errors_before = error_count;
    for (int r = 0; r < RANDOM_RUNS; r++) begin
      queue_random(rand_len[r]);
      run_vector(rand_len[r], 3, 1'b0);
    end
    report_test("random vectors", errors_before);

    // Latency errors of every element so far, taken out of the total
    report_test("result latency", error_count - latency_errors);

    errors_before = error_count;
    queue_random(MID_START_LEN);
    run_vector(MID_START_LEN, 3, 1'b1);
    report_test("start while busy", errors_before);

    $display("Tests run: %0d, checks: %0d, latency checks: %0d, errors: %0d",
             test_count, check_count, latency_checks, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* ntm_hidden_gate.f */
ntm_hidden_gate_pkg.sv
ntm_vector_tanh.sv
ntm_vector_multiplier.sv
ntm_hidden_gate_vector.sv
ntm_hidden_gate_vector_tb.sv

/* run_ntm_hidden_gate.sh */
#!/bin/sh
# Build and run the NTM hidden gate testbench with Verilator.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f ntm_hidden_gate.f \
  --top-module ntm_hidden_gate_vector_tb \
  -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vntm_hidden_gate_vector_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST PASS$'; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi
